//--- src/geom_pkg.sv
`default_nettype none

package geom_pkg;

    typedef logic [10:0] xpos_t;                // Horizontal pixel coordinate.
    typedef logic [9:0]  ypos_t;                // Vertical pixel coordinate.

    localparam int NUM_LAYERS = 5;              // Platform layers on screen.
    localparam int NUM_GAPS   = 3;              // Distinct gap shapes.

    // Playfield borders.
    localparam int XMIN = 10;                   // Left border.
    localparam int XMAX = 1268;                 // Right border.
    localparam int YMIN = 10;                   // Top border, also wrap target.
    localparam int YMAX = 789;                  // Bottom border.

    localparam int BLOCK_W = 32;                // Student block width.
    localparam int BLOCK_H = 32;                // Student block height.

    localparam int LAYER_THICK = 25;            // Layer wraps once this far past bottom.

    localparam ypos_t LAYER_RESET [NUM_LAYERS] = '{
        10'd150, 10'd320, 10'd500, 10'd660, 10'd830
    };

    // Each gap is the open span between left and right platform pieces.
    localparam xpos_t GAP_LEFT  [NUM_GAPS] = '{11'd300, 11'd900, 11'd580};
    localparam xpos_t GAP_RIGHT [NUM_GAPS] = '{11'd450, 11'd1200, 11'd800};

    localparam int LAYER_GAP [NUM_LAYERS] = '{0, 1, 2, 0, 1};   // Gap cut into each layer.
    localparam int JUMP_GAP  [NUM_LAYERS] = '{1, 0, 1, 2, 0};   // Gap of the layer above.

    localparam int LAND_BELOW = 5;              // Window reaches this far above a top.
    localparam int LAND_ABOVE = 6;              // And this far below it.

    localparam int JUMP_HIGH     = 200;         // Clears the gap onto the next layer.
    localparam int JUMP_LOW      = 100;         // Hop that lands back down.
    localparam int JUMP_LOW_LAST = 70;          // Bottom layer has less headroom.

    localparam int STEP    = 9;                 // Pixels per control step.
    localparam int GRAVITY = 7;                 // Fall per frame.

    localparam int RESPAWN_X = 700;             // Column after falling off.
    localparam int BLOCK_X0  = 140;             // Start column.
    localparam int BLOCK_Y0  = 200;             // Start row.

endpackage

`default_nettype wire

//--- src/game_pkg.sv
`default_nettype none

package game_pkg;

    typedef logic [2:0] diff_t;                 // Difficulty switches.
    typedef logic [2:0] speed_t;                // Layer scroll step.
    typedef logic [5:0] count_t;                // Deadline count.

    // Switch codes and their speeds; any other code falls to the default.
    localparam diff_t DIFF_SLOW = 3'b000;
    localparam diff_t DIFF_MID  = 3'b001;
    localparam diff_t DIFF_FAST = 3'b010;
    localparam diff_t DIFF_MAX  = 3'b100;

    localparam speed_t SPEED_SLOW    = 3'd1;
    localparam speed_t SPEED_MID     = 3'd2;
    localparam speed_t SPEED_FAST    = 3'd3;
    localparam speed_t SPEED_MAX     = 3'd4;
    localparam speed_t SPEED_DEFAULT = 3'd2;

    localparam int DEADLINE_LAYER_A = 1;        // Layer 2, zero based.
    localparam int DEADLINE_LAYER_B = 3;        // Layer 4.

    localparam int REMIND1_AT = 10;             // First reminder threshold.
    localparam int REMIND2_AT = 5;              // Second reminder.
    localparam int LOSE_AT    = 1;              // Deadline missed.

    localparam int NUM_ITEMS = 4;               // Homework items.

    localparam int ITEM_LAYER [NUM_ITEMS] = '{0, 2, 4, 1};          // Layer carrying each item.
    localparam int ITEM_X0    [NUM_ITEMS] = '{100, 900, 150, 600};  // Start columns.
    localparam int PARK_X     [NUM_ITEMS] = '{900, 1100, 900, 1100}; // Off-screen columns.
    localparam int PARK_Y     = 900;            // Off-screen row.
    localparam int ITEM_LIFT  = 40;             // Item rests this high above its layer.

endpackage

`default_nettype wire

//--- src/layer_if.sv
`timescale 1ns/1ps
`default_nettype none

interface layer_if;

    geom_pkg::ypos_t top [geom_pkg::NUM_LAYERS];   // Current top row of each layer.
    logic            deadline_wrap;                // Layer 2 or 4 wraps this frame.

    // Scroller owns the layers.
    modport scroller (
        output top,
        output deadline_wrap
    );

    // Block and items only look at the layer rows.
    modport rider (
        input top
    );

    modport timer (
        input deadline_wrap
    );

endinterface

`default_nettype wire

//--- src/layer_scroller.sv
`timescale 1ns/1ps
`default_nettype none

module layer_scroller (
    input  logic            posclk,     // Frame clock.
    input  logic            rst,        // Synchronous reset.
    input  game_pkg::diff_t diff,       // Difficulty switches.
    layer_if.scroller       lanes       // Layer tops and wrap pulse.
);

    game_pkg::speed_t                speed;  // Pixels per frame.
    logic [geom_pkg::NUM_LAYERS-1:0] wrap;   // Layer leaves the bottom this frame.

    always_comb begin
        case (diff)
            game_pkg::DIFF_SLOW: speed = game_pkg::SPEED_SLOW;
            game_pkg::DIFF_MID:  speed = game_pkg::SPEED_MID;
            game_pkg::DIFF_FAST: speed = game_pkg::SPEED_FAST;
            game_pkg::DIFF_MAX:  speed = game_pkg::SPEED_MAX;
            default:             speed = game_pkg::SPEED_DEFAULT;   // Mixed switches.
        endcase
    end

    always_comb begin
        for (int i = 0; i < geom_pkg::NUM_LAYERS; i++) begin
            wrap[i] = (int'(lanes.top[i]) + geom_pkg::LAYER_THICK) > geom_pkg::YMAX;
        end
    end

    // Deadline ticks on the two middle-spaced layers only.
    assign lanes.deadline_wrap = wrap[game_pkg::DEADLINE_LAYER_A]
                               | wrap[game_pkg::DEADLINE_LAYER_B];

    always_ff @(posedge posclk) begin
        for (int i = 0; i < geom_pkg::NUM_LAYERS; i++) begin
            if (rst) begin
                lanes.top[i] <= geom_pkg::LAYER_RESET[i];
            end else if (wrap[i]) begin
                lanes.top[i] <= geom_pkg::ypos_t'(geom_pkg::YMIN);     // Back to the top.
            end else begin
                lanes.top[i] <= lanes.top[i] + geom_pkg::ypos_t'(speed); // Scroll down.
            end
        end
    end

    // Layer 5 starts below the border; once a top is on screen it never leaves it.
    for (genvar g = 0; g < geom_pkg::NUM_LAYERS; g++) begin : g_top_chk
        a_top_on_screen: assert property (
            @(posedge posclk) disable iff (rst)
            (lanes.top[g] <= geom_pkg::YMAX) |=> (lanes.top[g] <= geom_pkg::YMAX)
        );
    end

endmodule

`default_nettype wire

//--- src/deadline_timer.sv
`timescale 1ns/1ps
`default_nettype none

module deadline_timer #(
    parameter game_pkg::count_t DEADLINE_START = 6'd15   // Frames of wraps to the deadline.
) (
    input  logic             posclk,     // Frame clock.
    input  logic             rst,        // Synchronous reset.
    input  logic             start,      // Game running.
    layer_if.timer           lanes,      // Wrap pulse from the scroller.
    output game_pkg::count_t count,      // Remaining count.
    output logic             reminder1,  // First warning.
    output logic             reminder2,  // Second warning.
    output logic             lose        // Deadline reached.
);

    logic tick;  // Count this wrap.

    assign tick = lanes.deadline_wrap && start && (count != '0);   // Floor at zero.

    always_ff @(posedge posclk) begin
        if (rst) begin
            count     <= DEADLINE_START;
            reminder1 <= 1'b0;
            reminder2 <= 1'b0;
            lose      <= 1'b0;
        end else begin
            if (tick) begin
                count <= count - game_pkg::count_t'(1);
            end
            // Flags look at the registered count, so they trail it by a frame.
            if (int'(count) <= game_pkg::REMIND1_AT) begin
                reminder1 <= 1'b1;
            end
            if (int'(count) <= game_pkg::REMIND2_AT) begin
                reminder2 <= 1'b1;
            end
            if (int'(count) <= game_pkg::LOSE_AT) begin
                lose <= 1'b1;
            end
        end
    end

    // Outside reset the deadline only ever moves closer.
    a_count_down_only: assert property (
        @(posedge posclk) disable iff (rst)
        !rst |=> (count <= $past(count))
    );

endmodule

`default_nettype wire

//--- src/player_motion.sv
`timescale 1ns/1ps
`default_nettype none

module player_motion (
    input  logic            posclk,   // Frame clock.
    input  logic            rst,      // Synchronous reset.
    input  logic            left,     // Step left.
    input  logic            right,    // Step right.
    input  logic            down,     // Step down.
    input  logic            up,       // Jump while standing.
    layer_if.rider          lanes,    // Layer tops.
    output geom_pkg::xpos_t block_x,  // Block left edge.
    output geom_pkg::ypos_t block_y   // Block top edge.
);

    localparam int JUMP_MARGIN = 5;   // Slack around the target gap.

    int   x_now;        // Current position, signed for the math.
    int   y_now;
    int   bottom;       // Block bottom edge.
    int   x_next;       // Position for the next frame.
    int   y_next;
    int   layer_y;      // Top of the layer under test.
    int   gap;          // Gap cut into that layer.
    int   jgap;         // Gap of the layer to jump through.
    logic landed;       // Standing on some layer.
    logic respawn;      // Fell out of the bottom.

    always_comb begin
        x_now   = int'(block_x);
        y_now   = int'(block_y);
        bottom  = y_now + geom_pkg::BLOCK_H;
        x_next  = x_now;
        y_next  = y_now;
        layer_y = 0;
        gap     = 0;
        jgap    = 0;
        landed  = 1'b0;
        respawn = 1'b0;

        if (left) x_next = x_next - geom_pkg::STEP;
        if (right) x_next = x_next + geom_pkg::STEP;    // Both held cancel out.
        if (down) y_next = y_next + geom_pkg::STEP;

        // Keep the whole block inside the borders.
        if (x_next < geom_pkg::XMIN) x_next = geom_pkg::XMIN;
        if (x_next > geom_pkg::XMAX - geom_pkg::BLOCK_W) begin
            x_next = geom_pkg::XMAX - geom_pkg::BLOCK_W;
        end
        if (y_next < geom_pkg::YMIN) y_next = geom_pkg::YMIN;

        if (bottom > geom_pkg::YMAX) begin
            respawn = 1'b1;
            x_next  = geom_pkg::RESPAWN_X;
            y_next  = geom_pkg::YMIN;
        end

        // Upper layers are tested first.
        for (int l = 0; l < geom_pkg::NUM_LAYERS; l++) begin
            layer_y = int'(lanes.top[l]);
            gap     = geom_pkg::LAYER_GAP[l];
            jgap    = geom_pkg::JUMP_GAP[l];
            if (!landed
                && bottom >= layer_y - geom_pkg::LAND_BELOW
                && bottom < layer_y + geom_pkg::LAND_ABOVE
                && (x_now < int'(geom_pkg::GAP_LEFT[gap])
                    || x_now + geom_pkg::BLOCK_W > int'(geom_pkg::GAP_RIGHT[gap]))) begin
                landed = 1'b1;
                y_next = layer_y - geom_pkg::BLOCK_H;              // Stand on it.
                if (up) begin
                    if (x_now + geom_pkg::BLOCK_W < int'(geom_pkg::GAP_RIGHT[jgap]) + JUMP_MARGIN
                        && x_now > int'(geom_pkg::GAP_LEFT[jgap]) - JUMP_MARGIN) begin
                        y_next = y_now - geom_pkg::JUMP_HIGH;      // Through the gap above.
                    end else if (l == geom_pkg::NUM_LAYERS - 1) begin
                        y_next = y_now - geom_pkg::JUMP_LOW_LAST;
                    end else begin
                        y_next = y_now - geom_pkg::JUMP_LOW;       // Falls back down.
                    end
                    if (y_next < geom_pkg::YMIN) y_next = geom_pkg::YMIN;
                end
            end
        end

        if (!landed && !respawn) begin
            y_next = y_next + geom_pkg::GRAVITY;
        end
    end

    always_ff @(posedge posclk) begin
        if (rst) begin
            block_x <= geom_pkg::xpos_t'(geom_pkg::BLOCK_X0);
            block_y <= geom_pkg::ypos_t'(geom_pkg::BLOCK_Y0);
        end else begin
            block_x <= geom_pkg::xpos_t'(x_next);
            block_y <= geom_pkg::ypos_t'(y_next);
        end
    end

    // Any frame of motion, respawn included, leaves the block between the side borders.
    a_x_in_bounds: assert property (
        @(posedge posclk) disable iff (rst)
        !rst |=> (int'(block_x) >= geom_pkg::XMIN
                  && int'(block_x) <= geom_pkg::XMAX - geom_pkg::BLOCK_W)
    );

endmodule

`default_nettype wire

//--- src/item_collector.sv
`timescale 1ns/1ps
`default_nettype none

module item_collector #(
    parameter int ITEM_SIZE = 32   // Item box edge.
) (
    input  logic                          posclk,    // Frame clock.
    input  logic                          rst,       // Synchronous reset.
    layer_if.rider                        lanes,     // Layer tops.
    input  geom_pkg::xpos_t               block_x,   // Block left edge.
    input  geom_pkg::ypos_t               block_y,   // Block top edge.
    output geom_pkg::xpos_t               item_x [game_pkg::NUM_ITEMS],  // Item columns.
    output geom_pkg::ypos_t               item_y [game_pkg::NUM_ITEMS],  // Item rows.
    output logic [game_pkg::NUM_ITEMS-1:0] collected, // Picked up so far.
    output logic                          win        // Every item picked up.
);

    logic [game_pkg::NUM_ITEMS-1:0] hit;   // Block overlaps the item box.

    always_comb begin
        for (int i = 0; i < game_pkg::NUM_ITEMS; i++) begin
            hit[i] = (int'(block_x) + geom_pkg::BLOCK_W > int'(item_x[i]))
                  && (int'(block_x) < int'(item_x[i]) + ITEM_SIZE)
                  && (int'(block_y) + geom_pkg::BLOCK_H > int'(item_y[i]))
                  && (int'(block_y) < int'(item_y[i]) + ITEM_SIZE);
        end
    end

    always_ff @(posedge posclk) begin
        for (int i = 0; i < game_pkg::NUM_ITEMS; i++) begin
            if (rst) begin
                collected[i] <= 1'b0;
                item_x[i]    <= geom_pkg::xpos_t'(game_pkg::ITEM_X0[i]);
                item_y[i]    <= geom_pkg::ypos_t'(
                    int'(geom_pkg::LAYER_RESET[game_pkg::ITEM_LAYER[i]]) - game_pkg::ITEM_LIFT);
            end else if (!collected[i]) begin   // Parked items stay put.
                if (hit[i]) begin
                    collected[i] <= 1'b1;
                    item_x[i]    <= geom_pkg::xpos_t'(game_pkg::PARK_X[i]);
                    item_y[i]    <= geom_pkg::ypos_t'(game_pkg::PARK_Y);
                end else if (int'(item_y[i]) + ITEM_SIZE > geom_pkg::YMAX) begin
                    item_y[i] <= geom_pkg::ypos_t'(geom_pkg::YMIN);     // Off the bottom.
                end else begin
                    item_y[i] <= lanes.top[game_pkg::ITEM_LAYER[i]]
                               - geom_pkg::ypos_t'(game_pkg::ITEM_LIFT); // Ride the layer.
                end
            end
        end
    end

    assign win = &collected;

    // Collection is permanent for the rest of the game.
    for (genvar g = 0; g < game_pkg::NUM_ITEMS; g++) begin : g_sticky_chk
        a_collected_sticky: assert property (
            @(posedge posclk) disable iff (rst)
            collected[g] |=> collected[g]
        );
    end

endmodule

`default_nettype wire

//--- src/game_top.sv
`timescale 1ns/1ps
`default_nettype none

module game_top #(
    parameter game_pkg::count_t DEADLINE_START = 6'd15,   // Starting deadline count.
    parameter int               ITEM_SIZE      = 32       // Item box edge.
) (
    input  logic                           posclk,     // Frame clock.
    input  logic                           rst,        // Synchronous reset.
    input  logic                           left,       // Controls.
    input  logic                           right,
    input  logic                           down,
    input  logic                           up,
    input  logic                           start,      // Deadline runs.
    input  game_pkg::diff_t                diff,       // Difficulty switches.
    output geom_pkg::xpos_t                block_x,    // Student block.
    output geom_pkg::ypos_t                block_y,
    output geom_pkg::ypos_t                layer_top [geom_pkg::NUM_LAYERS],
    output geom_pkg::xpos_t                item_x [game_pkg::NUM_ITEMS],
    output geom_pkg::ypos_t                item_y [game_pkg::NUM_ITEMS],
    output logic [game_pkg::NUM_ITEMS-1:0] collected,
    output game_pkg::count_t               count,      // Raw count for the display.
    output logic                           reminder1,
    output logic                           reminder2,
    output logic                           lose,
    output logic                           win
);

    layer_if lanes ();

    layer_scroller layer_scroller_inst (
        .posclk (posclk),
        .rst    (rst),
        .diff   (diff),
        .lanes  (lanes)
    );

    deadline_timer #(
        .DEADLINE_START (DEADLINE_START)
    ) deadline_timer_inst (
        .posclk    (posclk),
        .rst       (rst),
        .start     (start),
        .lanes     (lanes),
        .count     (count),
        .reminder1 (reminder1),
        .reminder2 (reminder2),
        .lose      (lose)
    );

    player_motion player_motion_inst (
        .posclk  (posclk),
        .rst     (rst),
        .left    (left),
        .right   (right),
        .down    (down),
        .up      (up),
        .lanes   (lanes),
        .block_x (block_x),
        .block_y (block_y)
    );

    item_collector #(
        .ITEM_SIZE (ITEM_SIZE)
    ) item_collector_inst (
        .posclk    (posclk),
        .rst       (rst),
        .lanes     (lanes),
        .block_x   (block_x),
        .block_y   (block_y),
        .item_x    (item_x),
        .item_y    (item_y),
        .collected (collected),
        .win       (win)
    );

    assign layer_top = lanes.top;   // Layer rows for the display.

endmodule

`default_nettype wire

//--- bench/game_checks.svh
`ifndef GAME_CHECKS_SVH
`define GAME_CHECKS_SVH

int model_top [geom_pkg::NUM_LAYERS];   // Expected layer tops.

// Scroll speed for each switch code.
function automatic int speed_for(input int code);
    case (code)
        0: return 1;
        1: return 2;
        2: return 3;
        4: return 4;
        default: return 2;              // Mixed switch settings.
    endcase
endfunction

task automatic model_step(input int code);
    for (int i = 0; i < geom_pkg::NUM_LAYERS; i++) begin
        if (model_top[i] + geom_pkg::LAYER_THICK > geom_pkg::YMAX) begin
            model_top[i] = geom_pkg::YMIN;     // Wraps to the top row.
        end else begin
            model_top[i] = model_top[i] + speed_for(code);
        end
    end
endtask

task automatic check_value(input string name, input int expected, input int actual);
    checks++;
    if (expected != actual) begin
        errors++;
        $display("[ERROR] %s expected 0x%0h actual 0x%0h at %0t", name, expected, actual, $time);
    end
endtask

task automatic check_layers();
    for (int i = 0; i < geom_pkg::NUM_LAYERS; i++) begin
        check_value($sformatf("layer_top[%0d]", i), model_top[i], int'(layer_top[i]));
    end
endtask

task automatic check_reset();
    int lift_y;
    for (int i = 0; i < geom_pkg::NUM_LAYERS; i++) begin
        model_top[i] = geom_pkg::LAYER_RESET[i];
    end
    check_layers();
    check_value("count", 15, int'(count));  // Deadline start value.
    check_value("reminder1", 0, int'(reminder1));
    check_value("reminder2", 0, int'(reminder2));
    check_value("lose", 0, int'(lose));
    check_value("win", 0, int'(win));
    check_value("collected", 0, int'(collected));
    check_value("block_x", geom_pkg::BLOCK_X0, int'(block_x));
    check_value("block_y", geom_pkg::BLOCK_Y0, int'(block_y));
    for (int i = 0; i < game_pkg::NUM_ITEMS; i++) begin
        lift_y = geom_pkg::LAYER_RESET[game_pkg::ITEM_LAYER[i]] - game_pkg::ITEM_LIFT;
        check_value($sformatf("item_x[%0d]", i), game_pkg::ITEM_X0[i], int'(item_x[i]));
        check_value($sformatf("item_y[%0d]", i), lift_y, int'(item_y[i]));
    end
    prev_y    = int'(block_y);
    prev_coll = collected;
endtask

// Checks that hold on every frame.
task automatic frame_checks();
    check_layers();
    checks++;
    if (int'(block_x) < geom_pkg::XMIN || int'(block_x) > geom_pkg::XMAX - geom_pkg::BLOCK_W) begin
        errors++;
        $display("[ERROR] block_x 0x%0h outside 0x%0h to 0x%0h", block_x, geom_pkg::XMIN,
                 geom_pkg::XMAX - geom_pkg::BLOCK_W);
    end
    if (prev_y + geom_pkg::BLOCK_H > geom_pkg::YMAX) begin   // Fell out last frame.
        check_value("block_x", geom_pkg::RESPAWN_X, int'(block_x));
        check_value("block_y", geom_pkg::YMIN, int'(block_y));
    end
    for (int i = 0; i < game_pkg::NUM_ITEMS; i++) begin
        if (prev_coll[i] && !collected[i]) begin
            errors++;
            $display("[ERROR] collected[%0d] expected 0x1 actual 0x0", i);
        end
        if (collected[i]) begin
            check_value($sformatf("item_x[%0d]", i), game_pkg::PARK_X[i], int'(item_x[i]));
            check_value($sformatf("item_y[%0d]", i), game_pkg::PARK_Y, int'(item_y[i]));
        end
    end
    check_value("win", ($countones(collected) == game_pkg::NUM_ITEMS) ? 1 : 0, int'(win));
    prev_y    = int'(block_y);
    prev_coll = collected;
endtask

`endif

//--- bench/game_tb.sv
`timescale 1ns/1ps
`default_nettype none

module game_tb;

    logic                           posclk = 1'b0;
    logic                           rst;
    logic                           left;
    logic                           right;
    logic                           down;
    logic                           up;
    logic                           start;
    game_pkg::diff_t                diff;
    geom_pkg::xpos_t                block_x;
    geom_pkg::ypos_t                block_y;
    geom_pkg::ypos_t                layer_top [geom_pkg::NUM_LAYERS];
    geom_pkg::xpos_t                item_x [game_pkg::NUM_ITEMS];
    geom_pkg::ypos_t                item_y [game_pkg::NUM_ITEMS];
    logic [game_pkg::NUM_ITEMS-1:0] collected;
    game_pkg::count_t               count;
    logic                           reminder1;
    logic                           reminder2;
    logic                           lose;
    logic                           win;

    int                             errors = 0;
    int                             checks = 0;
    int                             cycles = 0;
    int                             cycle_limit = 100;  // Segment lengths get added.
    int                             prev_y;             // Block row one frame back.
    logic [game_pkg::NUM_ITEMS-1:0] prev_coll;
    int                             seg [64][9];        // One row per file line.
    int                             num_segs = 0;

    `include "game_checks.svh"

    always #4 posclk = ~posclk;                         // 8 ns frame clock.

    game_top game_top_inst (.*);

    initial begin
        while (cycles <= cycle_limit) begin
            @(posedge posclk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the segments never finished", cycles);
        $display("Test failed");
        $finish;
    end

    initial begin
        int          fd;
        int          n;
        logic [31:0] ctrl;
        string       line;
        ctrl  = $urandom(32'hec46d98e);                 // Seeds the generator.
        rst   = 1'b1;
        left  = 1'b0;
        right = 1'b0;
        down  = 1'b0;
        up    = 1'b0;
        start = 1'b0;
        diff  = '0;
        fd = $fopen("bench/game_input.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("[ERROR] Could not open bench/game_input.txt");
        end else begin
            while (!$feof(fd) && num_segs < 64) begin
                n = $fgets(line, fd);
                if (n > 1 && line.substr(0, 0) != "#") begin
                    n = $sscanf(line, "%h %h %h %h %d %h %h %h %h", seg[num_segs][0],
                        seg[num_segs][1], seg[num_segs][2], seg[num_segs][3], seg[num_segs][4],
                        seg[num_segs][5], seg[num_segs][6], seg[num_segs][7], seg[num_segs][8]);
                    if (n == 9) begin
                        cycle_limit += seg[num_segs][4];
                        num_segs++;
                    end else begin
                        errors++;
                        $display("[ERROR] Malformed stimulus line: %s", line);
                    end
                end
            end
            $fclose(fd);
        end
        repeat (10) @(posedge posclk);
        @(negedge posclk);
        check_reset();
        rst = 1'b0;
        for (int s = 0; s < num_segs; s++) begin
            for (int c = 0; c < seg[s][4]; c++) begin
                diff  = game_pkg::diff_t'(seg[s][0]);
                start = seg[s][1][0];
                ctrl  = (seg[s][3] != 0) ? $urandom : seg[s][2];  // Random or fixed keys.
                {left, right, down, up} = ctrl[3:0];
                model_step(seg[s][0]);
                @(negedge posclk);
                frame_checks();
            end
            check_value("count", seg[s][5], int'(count));
            check_value("reminder1", seg[s][6] & 1, int'(reminder1));
            check_value("reminder2", (seg[s][6] >> 1) & 1, int'(reminder2));
            check_value("lose", seg[s][7], int'(lose));
            if (seg[s][8] < 16) begin
                check_value("collected", seg[s][8], int'(collected));
            end
        end
        $display("Run complete: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/game_input.txt
# diff start keys(left,right,down,up) random length | count reminders(r2,r1) lose collected
# All hex except length; collected 10 skips that check, random 1 draws keys from $urandom.
0 0 0 0 120 0f 0 0 0
4 1 0 0 100 0e 0 0 0
1 0 0 0 60 0e 0 0 0
2 0 0 0 60 0e 0 0 0
3 1 0 0 40 0d 0 0 0
7 0 0 0 40 0d 0 0 0
4 1 0 1 250 0a 1 0 10
4 1 4 0 500 05 3 0 10
4 0 8 0 100 05 3 0 10
4 1 0 1 400 01 3 1 10
4 1 3 0 200 00 3 1 10

//--- compile.f
+incdir+bench
src/geom_pkg.sv
src/game_pkg.sv
src/layer_if.sv
src/layer_scroller.sv
src/deadline_timer.sv
src/player_motion.sv
src/item_collector.sv
src/game_top.sv
bench/game_tb.sv

//--- Bender.yml
package:
  name: platform_game

sources:
  - src/geom_pkg.sv
  - src/game_pkg.sv
  - src/layer_if.sv
  - src/layer_scroller.sv
  - src/deadline_timer.sv
  - src/player_motion.sv
  - src/item_collector.sv
  - src/game_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/game_tb.sv
